// File: design/vgaPkg.sv
package vgaPkg;

	typedef logic [7:0] colorT;    // one colour channel
	typedef logic [9:0] xCoordT;
	typedef logic [9:0] yCoordT;
	typedef logic [6:0] segmentsT; // active low, bit 0 top ... bit 6 centre

	////////////////////////////////////////////////////////////////////////////
	// 640x480 at 60 Hz, 25 MHz pixel clock
	////////////////////////////////////////////////////////////////////////////
	localparam int hActive = 640;
	localparam int hFront  = 16;
	localparam int hSync   = 96;
	localparam int hBack   = 48;
	localparam int hTotal  = hActive + hFront + hSync + hBack; // 800

	localparam int vActive = 480;
	localparam int vFront  = 10;
	localparam int vSync   = 2;
	localparam int vBack   = 33;
	localparam int vTotal  = vActive + vFront + vSync + vBack; // 525

	// sync windows, start inclusive and end exclusive
	localparam int hSyncStart = hActive + hFront;
	localparam int hSyncEnd   = hSyncStart + hSync;
	localparam int vSyncStart = vActive + vFront;
	localparam int vSyncEnd   = vSyncStart + vSync;

	////////////////////////////////////////////////////////////////////////////
	// digit geometry and placement
	////////////////////////////////////////////////////////////////////////////
	localparam int segLenBig     = 60;
	localparam int segThickBig   = 6;
	localparam int segGapBig     = 3;
	localparam int segLenSmall   = 30;
	localparam int segThickSmall = 3;
	localparam int segGapSmall   = 2;

	localparam xCoordT scoreTensX = 10'd390;
	localparam yCoordT scoreTensY = 10'd15;
	localparam xCoordT scoreOnesX = 10'd480;
	localparam yCoordT scoreOnesY = 10'd15;
	localparam xCoordT timeTensX  = 10'd390;
	localparam yCoordT timeTensY  = 10'd215;
	localparam xCoordT timeOnesX  = 10'd480;
	localparam yCoordT timeOnesY  = 10'd215;

	// leaderboard column, three rows
	localparam xCoordT lbTensX = 10'd10;
	localparam xCoordT lbOnesX = 10'd55;
	localparam yCoordT lb1Y    = 10'd5;
	localparam yCoordT lb2Y    = 10'd85;
	localparam yCoordT lb3Y    = 10'd165;

	// colours
	localparam colorT digitRed   = 8'd255;
	localparam colorT digitGreen = 8'd0;
	localparam colorT digitBlue  = 8'd0;
	localparam colorT bgRed      = 8'd0;
	localparam colorT bgGreen    = 8'd64;
	localparam colorT bgBlue     = 8'd128;

endpackage

// File: design/videoSyncGenerator.sv
`timescale 1ns/100ps

module videoSyncGenerator
	import vgaPkg::*;
(
	input  logic   VGA_CLK_n,
	input  logic   iRST_n,
	output xCoordT pixelX,
	output yCoordT pixelY,
	output logic   activeVideo,
	output logic   rawHSync,
	output logic   rawVSync
);

	xCoordT nextX;
	yCoordT nextY;
	logic   lineEnd;

	////////////////////////////////////////////////////////////////////////////
	// next counter state
	////////////////////////////////////////////////////////////////////////////
	assign lineEnd = (pixelX == xCoordT'(hTotal - 1));

	always_comb
	begin
		nextX = pixelX + 1'b1;
		nextY = pixelY;
		if (lineEnd)
		begin
			nextX = '0;
			if (pixelY == yCoordT'(vTotal - 1))
				nextY = '0; // frame wrap
			else
				nextY = pixelY + 1'b1;
		end
	end

	// flags decoded from the next state so they line up with the counters
	always_ff @(posedge VGA_CLK_n or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			pixelX      <= '0;
			pixelY      <= '0;
			activeVideo <= 1'b1; // (0,0) is visible
			rawHSync    <= 1'b1;
			rawVSync    <= 1'b1;
		end
		else
		begin
			pixelX      <= nextX;
			pixelY      <= nextY;
			activeVideo <= (nextX < hActive) && (nextY < vActive);
			rawHSync    <= !((nextX >= hSyncStart) && (nextX < hSyncEnd)); // active low
			rawVSync    <= !((nextY >= vSyncStart) && (nextY < vSyncEnd));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////
	xInRange: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		pixelX < hTotal);

	yInRange: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		pixelY < vTotal);

	// vertical sync edges belong to the start of a line
	vSyncOnLineStart: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		$changed(rawVSync) |-> pixelX == '0);

endmodule

// File: design/segmentDigitRenderer.sv
`timescale 1ns/100ps

module segmentDigitRenderer
	import vgaPkg::*;
#(
	parameter int originX  = 0,
	parameter int originY  = 0,
	parameter int segLen   = 60,
	parameter int segThick = 6,
	parameter int segGap   = 3
)
(
	input  xCoordT   pixelX,
	input  yCoordT   pixelY,
	input  segmentsT segments,
	output logic     lit
);

	logic signed [11:0] relX; // may go negative left of the digit
	logic signed [11:0] relY;
	segmentsT           hit;  // pixel inside segment rectangle

	logic rowTop, rowUpper, rowLower, rowBottom, rowCentre;
	logic colFull, colLeft, colRight, colCentre;

	function automatic logic inRange(input logic signed [11:0] v, input int lo, input int hi);
		return (v >= lo) && (v <= hi);
	endfunction

	assign relX = $signed({2'b00, pixelX}) - 12'(originX);
	assign relY = $signed({2'b00, pixelY}) - 12'(originY);

	////////////////////////////////////////////////////////////////////////////
	// row bands, top to bottom
	////////////////////////////////////////////////////////////////////////////
	assign rowTop    = inRange(relY, 0, segThick);
	assign rowUpper  = inRange(relY, segThick + segGap, segThick + segGap + segLen);
	assign rowLower  = inRange(relY, segThick + 2*segGap + segLen,
		segThick + 2*segGap + 2*segLen);
	assign rowBottom = inRange(relY, segThick + 3*segGap + 2*segLen,
		2*segThick + 3*segGap + 2*segLen);
	assign rowCentre = inRange(relY, segThick + segGap + segLen,
		2*segThick + segGap + segLen);

	// column bands
	assign colFull   = inRange(relX, 0, segLen + segGap + segThick);
	assign colLeft   = inRange(relX, 0, segThick);
	assign colRight  = inRange(relX, segLen + segGap, segLen + segGap + segThick);
	assign colCentre = inRange(relX, segThick + segGap, segLen);

	assign hit[0] = rowTop    && colFull;   // top
	assign hit[1] = rowUpper  && colRight;  // upper right
	assign hit[2] = rowLower  && colRight;  // lower right
	assign hit[3] = rowBottom && colFull;   // bottom
	assign hit[4] = rowLower  && colLeft;   // lower left
	assign hit[5] = rowUpper  && colLeft;   // upper left
	assign hit[6] = rowCentre && colCentre; // centre bar

	// a segment shows when its pattern bit is 0
	assign lit = |(hit & ~segments);

endmodule

// File: design/pixelComposer.sv
`timescale 1ns/100ps

module pixelComposer
	import vgaPkg::*;
(
	input  logic     VGA_CLK_n,
	input  logic     iRST_n,
	input  xCoordT   pixelX,
	input  yCoordT   pixelY,
	input  logic     activeVideo,
	input  logic     rawHSync,
	input  logic     rawVSync,
	input  segmentsT scoreOnes,
	input  segmentsT scoreTens,
	input  segmentsT timeOnes,
	input  segmentsT timeTens,
	input  segmentsT lb1Ones,
	input  segmentsT lb1Tens,
	input  segmentsT lb2Ones,
	input  segmentsT lb2Tens,
	input  segmentsT lb3Ones,
	input  segmentsT lb3Tens,
	output colorT    red,
	output colorT    green,
	output colorT    blue,
	output logic     hSync,
	output logic     vSync,
	output logic     blankN
);

	logic [9:0] litVec; // one per digit
	colorT      nextRed, nextGreen, nextBlue;

	////////////////////////////////////////////////////////////////////////////
	// score and time, large digits
	////////////////////////////////////////////////////////////////////////////
	segmentDigitRenderer #(.originX(scoreTensX), .originY(scoreTensY), .segLen(segLenBig),
		.segThick(segThickBig), .segGap(segGapBig)) scoreTensDigit (.pixelX(pixelX),
		.pixelY(pixelY), .segments(scoreTens), .lit(litVec[0]));
	segmentDigitRenderer #(.originX(scoreOnesX), .originY(scoreOnesY), .segLen(segLenBig),
		.segThick(segThickBig), .segGap(segGapBig)) scoreOnesDigit (.pixelX(pixelX),
		.pixelY(pixelY), .segments(scoreOnes), .lit(litVec[1]));
	segmentDigitRenderer #(.originX(timeTensX), .originY(timeTensY), .segLen(segLenBig),
		.segThick(segThickBig), .segGap(segGapBig)) timeTensDigit (.pixelX(pixelX),
		.pixelY(pixelY), .segments(timeTens), .lit(litVec[2]));
	segmentDigitRenderer #(.originX(timeOnesX), .originY(timeOnesY), .segLen(segLenBig),
		.segThick(segThickBig), .segGap(segGapBig)) timeOnesDigit (.pixelX(pixelX),
		.pixelY(pixelY), .segments(timeOnes), .lit(litVec[3]));

	// leaderboard, small digits
	segmentDigitRenderer #(.originX(lbTensX), .originY(lb1Y), .segLen(segLenSmall),
		.segThick(segThickSmall), .segGap(segGapSmall)) lb1TensDigit (.pixelX(pixelX),
		.pixelY(pixelY), .segments(lb1Tens), .lit(litVec[4]));
	segmentDigitRenderer #(.originX(lbOnesX), .originY(lb1Y), .segLen(segLenSmall),
		.segThick(segThickSmall), .segGap(segGapSmall)) lb1OnesDigit (.pixelX(pixelX),
		.pixelY(pixelY), .segments(lb1Ones), .lit(litVec[5]));
	segmentDigitRenderer #(.originX(lbTensX), .originY(lb2Y), .segLen(segLenSmall),
		.segThick(segThickSmall), .segGap(segGapSmall)) lb2TensDigit (.pixelX(pixelX),
		.pixelY(pixelY), .segments(lb2Tens), .lit(litVec[6]));
	segmentDigitRenderer #(.originX(lbOnesX), .originY(lb2Y), .segLen(segLenSmall),
		.segThick(segThickSmall), .segGap(segGapSmall)) lb2OnesDigit (.pixelX(pixelX),
		.pixelY(pixelY), .segments(lb2Ones), .lit(litVec[7]));
	segmentDigitRenderer #(.originX(lbTensX), .originY(lb3Y), .segLen(segLenSmall),
		.segThick(segThickSmall), .segGap(segGapSmall)) lb3TensDigit (.pixelX(pixelX),
		.pixelY(pixelY), .segments(lb3Tens), .lit(litVec[8]));
	segmentDigitRenderer #(.originX(lbOnesX), .originY(lb3Y), .segLen(segLenSmall),
		.segThick(segThickSmall), .segGap(segGapSmall)) lb3OnesDigit (.pixelX(pixelX),
		.pixelY(pixelY), .segments(lb3Ones), .lit(litVec[9]));

	////////////////////////////////////////////////////////////////////////////
	// colour select and output register
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		{nextRed, nextGreen, nextBlue} = {bgRed, bgGreen, bgBlue};
		if (!activeVideo)
			{nextRed, nextGreen, nextBlue} = '0; // porch and sync are black
		else if (|litVec)
			{nextRed, nextGreen, nextBlue} = {digitRed, digitGreen, digitBlue};
	end

	// colour, sync and blank leave together, one clock after the counters
	always_ff @(posedge VGA_CLK_n or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			{red, green, blue} <= '0;
			hSync              <= 1'b1;
			vSync              <= 1'b1;
			blankN             <= 1'b0;
		end
		else
		begin
			{red, green, blue} <= {nextRed, nextGreen, nextBlue};
			hSync              <= rawHSync;
			vSync              <= rawVSync;
			blankN             <= activeVideo;
		end
	end

	blackWhenBlank: assert property (@(posedge VGA_CLK_n) disable iff (!iRST_n)
		!blankN |-> (red == '0) && (green == '0) && (blue == '0));

endmodule

// File: design/vgaController.sv
`timescale 1ns/100ps

module vgaController
	import vgaPkg::*;
(
	input  logic     VGA_CLK_n,
	input  logic     iRST_n,
	input  segmentsT scoreOnes,
	input  segmentsT scoreTens,
	input  segmentsT timeOnes,
	input  segmentsT timeTens,
	input  segmentsT lb1Ones,
	input  segmentsT lb1Tens,
	input  segmentsT lb2Ones,
	input  segmentsT lb2Tens,
	input  segmentsT lb3Ones,
	input  segmentsT lb3Tens,
	output colorT    red,
	output colorT    green,
	output colorT    blue,
	output logic     hSync,
	output logic     vSync,
	output logic     blankN
);

	xCoordT pixelX;
	yCoordT pixelY;
	logic   activeVideo;
	logic   rawHSync;   // before output alignment
	logic   rawVSync;

	////////////////////////////////////////////////////////////////////////////
	// timing
	////////////////////////////////////////////////////////////////////////////
	videoSyncGenerator syncGen (
		.VGA_CLK_n   (VGA_CLK_n),
		.iRST_n      (iRST_n),
		.pixelX      (pixelX),
		.pixelY      (pixelY),
		.activeVideo (activeVideo),
		.rawHSync    (rawHSync),
		.rawVSync    (rawVSync)
	);

	// digit overlay and output stage
	pixelComposer composer (
		.VGA_CLK_n   (VGA_CLK_n),
		.iRST_n      (iRST_n),
		.pixelX      (pixelX),
		.pixelY      (pixelY),
		.activeVideo (activeVideo),
		.rawHSync    (rawHSync),
		.rawVSync    (rawVSync),
		.scoreOnes   (scoreOnes),
		.scoreTens   (scoreTens),
		.timeOnes    (timeOnes),
		.timeTens    (timeTens),
		.lb1Ones     (lb1Ones),
		.lb1Tens     (lb1Tens),
		.lb2Ones     (lb2Ones),
		.lb2Tens     (lb2Tens),
		.lb3Ones     (lb3Ones),
		.lb3Tens     (lb3Tens),
		.red         (red),
		.green       (green),
		.blue        (blue),
		.hSync       (hSync),
		.vSync       (vSync),
		.blankN      (blankN)
	);

endmodule

// File: dv/tbClockGen.sv
`timescale 1ns/100ps

module tbClockGen #(
	parameter int periodNs    = 40,
	parameter int resetCycles = 3
)
(
	output logic VGA_CLK_n,
	output logic iRST_n
);

	initial
	begin
		VGA_CLK_n = 1'b0;
		forever
			#(periodNs / 2) VGA_CLK_n = ~VGA_CLK_n;
	end

	// release a quarter period after the last reset edge
	initial
	begin
		iRST_n = 1'b0;
		repeat (resetCycles) @(posedge VGA_CLK_n);
		#(periodNs / 4);
		iRST_n = 1'b1;
	end

endmodule

// File: dv/vgaControllerTb.sv
`timescale 1ns/100ps

module vgaControllerTb
	import vgaPkg::*;
();

	localparam int resetClocks = 3;
	localparam int frameWait   = 2 * hTotal * vTotal + 16;

	logic     VGA_CLK_n;
	logic     iRST_n;
	segmentsT scoreOnes, scoreTens, timeOnes, timeTens;
	segmentsT lb1Ones, lb1Tens, lb2Ones, lb2Tens, lb3Ones, lb3Tens;
	colorT    vgaRed, vgaGreen, vgaBlue;
	logic     vgaHSync, vgaVSync, vgaBlankN;

	// position tracker, rebuilt from the outputs only
	int          trackX, trackY, lineCount;
	int          risingEdges = 0;
	logic        synced, lineStart, prevBlankN, prevVSync;
	logic [31:0] rngState;

	// probe pixels for the digit tests
	int    pointX[$];
	int    pointY[$];
	logic  pointLit[$];
	string pointName[$];

	tbClockGen #(.periodNs(40), .resetCycles(resetClocks)) clockGen (
		.VGA_CLK_n (VGA_CLK_n),
		.iRST_n    (iRST_n)
	);

	vgaController dut (
		.VGA_CLK_n (VGA_CLK_n), .iRST_n (iRST_n),
		.scoreOnes (scoreOnes), .scoreTens (scoreTens),
		.timeOnes  (timeOnes),  .timeTens  (timeTens),
		.lb1Ones   (lb1Ones),   .lb1Tens   (lb1Tens),
		.lb2Ones   (lb2Ones),   .lb2Tens   (lb2Tens),
		.lb3Ones   (lb3Ones),   .lb3Tens   (lb3Tens),
		.red       (vgaRed),    .green     (vgaGreen),   .blue (vgaBlue),
		.hSync     (vgaHSync),  .vSync     (vgaVSync),   .blankN (vgaBlankN)
	);

	always @(posedge VGA_CLK_n)
		risingEdges <= risingEdges + 1;

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////
	task automatic abortRun(input string line);
		$display("%s", line);
		$display("ERRORS FOUND");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic checkColor(input string what, input colorT gotR, input colorT gotG,
		input colorT gotB, input colorT expR, input colorT expG, input colorT expB);
		if (gotR !== expR || gotG !== expG || gotB !== expB)
			abortRun($sformatf("[FAIL] %0t: %s at (%0d,%0d) got %0d/%0d/%0d expected %0d/%0d/%0d",
				$time, what, trackX, trackY, gotR, gotG, gotB, expR, expG, expB));
	endtask

	task automatic checkCount(input string what, input int got, input int exp);
		if (got != exp)
			abortRun($sformatf("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic checkLevel(input string what, input logic got, input logic exp);
		if (got !== exp)
			abortRun($sformatf("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	// one falling edge, then update the tracker from the sampled outputs
	task automatic nextClock();
		@(negedge VGA_CLK_n);
		if (vgaVSync === 1'b1 && prevVSync === 1'b0)
		begin
			lineCount = 0; // end of vSync pulse
			synced    = 1'b1;
		end
		lineStart = (vgaBlankN === 1'b1) && (prevBlankN !== 1'b1);
		if (lineStart)
		begin
			trackX = 0;
			trackY = lineCount;
			lineCount++;
		end
		else if (vgaBlankN === 1'b1)
			trackX++;
		prevBlankN = vgaBlankN;
		prevVSync  = vgaVSync;
	endtask

	// always moves at least one clock, so a new full frame follows
	task automatic waitFrameStart();
		int waited;
		waited = 0;
		do
		begin
			nextClock();
			waited++;
			if (waited > frameWait)
				abortRun("timed out waiting for the start of a frame");
		end
		while (!(synced && lineStart && trackY == 0));
	endtask

	task automatic driveDigits(input segmentsT big[4], input segmentsT lbDigits[6]);
		scoreTens = big[0];
		scoreOnes = big[1];
		timeTens  = big[2];
		timeOnes  = big[3];
		lb1Tens   = lbDigits[0];
		lb1Ones   = lbDigits[1];
		lb2Tens   = lbDigits[2];
		lb2Ones   = lbDigits[3];
		lb3Tens   = lbDigits[4];
		lb3Ones   = lbDigits[5];
	endtask

	// centre of a segment rectangle relative to the digit origin
	function automatic void segmentCentre(input int seg, input int len, input int thick,
		input int gap, output int cx, output int cy);
		int rowLo, rowHi, colLo, colHi;
		colLo = 0;
		colHi = thick; // left column
		case (seg)
			0:
			begin
				rowLo = 0;
				rowHi = thick;
				colHi = len + gap + thick;
			end
			1, 5:
			begin
				rowLo = thick + gap;
				rowHi = thick + gap + len;
			end
			2, 4:
			begin
				rowLo = thick + 2 * gap + len;
				rowHi = thick + 2 * gap + 2 * len;
			end
			3:
			begin
				rowLo = thick + 3 * gap + 2 * len;
				rowHi = 2 * thick + 3 * gap + 2 * len;
				colHi = len + gap + thick;
			end
			default:
			begin
				rowLo = thick + gap + len;
				rowHi = 2 * thick + gap + len;
				colLo = thick + gap;
				colHi = len;
			end
		endcase
		if (seg == 1 || seg == 2)
		begin
			colLo = len + gap; // right column
			colHi = len + gap + thick;
		end
		cx = (colLo + colHi) / 2;
		cy = (rowLo + rowHi) / 2;
	endfunction

	task automatic addDigitPoints(input string name, input int ox, input int oy,
		input int len, input int thick, input int gap, input segmentsT pattern);
		int cx, cy;
		for (int seg = 0; seg < 7; seg++)
		begin
			segmentCentre(seg, len, thick, gap, cx, cy);
			pointX.push_back(ox + cx);
			pointY.push_back(oy + cy);
			pointLit.push_back(!pattern[seg]); // active low
			pointName.push_back($sformatf("%s segment %0d", name, seg));
		end
	endtask

	task automatic addCentrePoints(input string name, input int ox, input int oy);
		int cx, cy;
		segmentCentre(6, segLenSmall, segThickSmall, segGapSmall, cx, cy);
		pointX.push_back(ox + cx);
		pointY.push_back(oy + cy);
		pointLit.push_back(1'b1);
		pointName.push_back({name, " centre"});
		// one column outside the bar on each side
		pointX.push_back(ox + segThickSmall + segGapSmall - 1);
		pointY.push_back(oy + cy);
		pointLit.push_back(1'b0);
		pointName.push_back({name, " left of centre"});
		pointX.push_back(ox + segLenSmall + 1);
		pointY.push_back(oy + cy);
		pointLit.push_back(1'b0);
		pointName.push_back({name, " right of centre"});
	endtask

	// one full frame, every probe pixel compared
	task automatic scanPoints();
		int hits;
		hits = 0;
		waitFrameStart();
		for (int i = 0; i < hTotal * vTotal; i++)
		begin
			if (vgaBlankN === 1'b1)
				for (int p = 0; p < pointX.size(); p++)
					if (pointX[p] == trackX && pointY[p] == trackY)
					begin
						hits++;
						if (pointLit[p])
							checkColor(pointName[p], vgaRed, vgaGreen, vgaBlue,
								digitRed, digitGreen, digitBlue);
						else
							checkColor(pointName[p], vgaRed, vgaGreen, vgaBlue,
								bgRed, bgGreen, bgBlue);
					end
			nextClock();
		end
		checkCount("probe pixels visited", hits, pointX.size());
		pointX.delete();
		pointY.delete();
		pointLit.delete();
		pointName.delete();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////////////////////
	task automatic resetStateTest();
		int waited, sampled;
		waited  = 0;
		sampled = 0;
		do
		begin
			nextClock();
			waited++;
			if (waited > 20)
				abortRun("timed out waiting for reset to be released");
			if (iRST_n === 1'b0 && risingEdges > 0)
			begin
				checkLevel("hSync in reset", vgaHSync, 1'b1);
				checkLevel("vSync in reset", vgaVSync, 1'b1);
				checkLevel("blankN in reset", vgaBlankN, 1'b0);
				checkColor("colour in reset", vgaRed, vgaGreen, vgaBlue, 8'd0, 8'd0, 8'd0);
				sampled++;
			end
		end
		while (iRST_n !== 1'b1);
		checkCount("falling edges sampled in reset", sampled, resetClocks - 1);
	endtask

	task automatic syncTimingTest();
		int hLow, blankHigh, vLowLines, vLowClocks;
		vLowLines  = 0;
		vLowClocks = 0;
		waitFrameStart();
		for (int line = 0; line < vTotal; line++)
		begin
			hLow      = 0;
			blankHigh = 0;
			if (vgaVSync === 1'b0)
				vLowLines++;
			for (int px = 0; px < hTotal; px++)
			begin
				if (vgaHSync === 1'b0)
					hLow++;
				if (vgaBlankN === 1'b1)
					blankHigh++;
				if (vgaVSync === 1'b0)
					vLowClocks++;
				nextClock();
			end
			checkCount($sformatf("hSync low clocks in line %0d", line), hLow, hSync);
			checkCount($sformatf("blankN high clocks in line %0d", line), blankHigh,
				(line < vActive) ? hActive : 0);
		end
		checkCount("lines with vSync low", vLowLines, vSync);
		checkCount("clocks with vSync low", vLowClocks, vSync * hTotal);
		checkLevel("frame restart after 525 lines", synced && lineStart && trackY == 0, 1'b1);
	endtask

	task automatic backgroundTest();
		segmentsT big[4];
		segmentsT lbDigits[6];
		int active;
		foreach (big[i])
			big[i] = 7'h7F;
		foreach (lbDigits[i])
			lbDigits[i] = 7'h7F;
		driveDigits(big, lbDigits);
		active = 0;
		waitFrameStart();
		for (int i = 0; i < hTotal * vTotal; i++)
		begin
			if (vgaBlankN === 1'b1)
			begin
				active++;
				checkColor("background pixel", vgaRed, vgaGreen, vgaBlue, bgRed, bgGreen, bgBlue);
			end
			else
				checkColor("blanked pixel", vgaRed, vgaGreen, vgaBlue, 8'd0, 8'd0, 8'd0);
			nextClock();
		end
		checkCount("active pixels in frame", active, hActive * vActive);
	endtask

	task automatic largeDigitTest();
		segmentsT big[4];
		segmentsT lbDigits[6];
		foreach (big[i])
			big[i] = segmentsT'(nextRandom());
		foreach (lbDigits[i])
			lbDigits[i] = 7'h7F;
		driveDigits(big, lbDigits);
		addDigitPoints("score tens", scoreTensX, scoreTensY, segLenBig, segThickBig, segGapBig,
			big[0]);
		addDigitPoints("score ones", scoreOnesX, scoreOnesY, segLenBig, segThickBig, segGapBig,
			big[1]);
		addDigitPoints("time tens", timeTensX, timeTensY, segLenBig, segThickBig, segGapBig,
			big[2]);
		addDigitPoints("time ones", timeOnesX, timeOnesY, segLenBig, segThickBig, segGapBig,
			big[3]);
		scanPoints();
	endtask

	task automatic smallDigitTest();
		segmentsT big[4];
		segmentsT lbDigits[6];
		foreach (big[i])
			big[i] = 7'h7F;
		foreach (lbDigits[i])
			lbDigits[i] = segmentsT'(nextRandom());
		driveDigits(big, lbDigits);
		for (int d = 0; d < 6; d++)
			addDigitPoints($sformatf("leaderboard %0d %s", d / 2 + 1, (d % 2) ? "ones" : "tens"),
				(d % 2) ? lbOnesX : lbTensX, (d < 2) ? lb1Y : ((d < 4) ? lb2Y : lb3Y),
				segLenSmall, segThickSmall, segGapSmall, lbDigits[d]);
		scanPoints();
	endtask

	// only the centre bar lit on every leaderboard digit
	task automatic centreSegmentTest();
		segmentsT big[4];
		segmentsT lbDigits[6];
		foreach (big[i])
			big[i] = 7'h7F;
		foreach (lbDigits[i])
			lbDigits[i] = 7'h3F;
		driveDigits(big, lbDigits);
		for (int d = 0; d < 6; d++)
			addCentrePoints($sformatf("leaderboard %0d %s", d / 2 + 1, (d % 2) ? "ones" : "tens"),
				(d % 2) ? lbOnesX : lbTensX, (d < 2) ? lb1Y : ((d < 4) ? lb2Y : lb3Y));
		scanPoints();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		segmentsT big[4];
		segmentsT lbDigits[6];
		rngState   = 32'h0266_c78a;
		trackX     = 0;
		trackY     = 0;
		lineCount  = 0;
		synced     = 1'b0;
		lineStart  = 1'b0;
		prevBlankN = 1'b0;
		prevVSync  = 1'b1; // sync idles high
		foreach (big[i])
			big[i] = 7'h7F;
		foreach (lbDigits[i])
			lbDigits[i] = 7'h7F;
		driveDigits(big, lbDigits);

		resetStateTest();
		syncTimingTest();
		backgroundTest();
		largeDigitTest();
		smallDigitTest();
		centreSegmentTest();

		$display("NO ERRORS");
		$finish;
	end

endmodule

// File: all.f
design/vgaPkg.sv
design/videoSyncGenerator.sv
design/segmentDigitRenderer.sv
design/pixelComposer.sv
design/vgaController.sv
dv/tbClockGen.sv
dv/vgaControllerTb.sv

// File: run.sh
#!/usr/bin/env bash
# lint, build and run the VGA controller testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

TOP=vgaControllerTb
BUILD_DIR=obj_dir

verilator --lint-only --timing -Wno-fatal -f all.f --top-module "$TOP"
if [ $? -ne 0 ]; then
	echo "lint failed"
	exit 1
fi

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module "$TOP" \
	-Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$BUILD_DIR/$TOP"
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi
exit 0
